// File: hw/aes_front_pkg.sv
// AES front end package with widths, address windows, bus and key-vault types
package aes_front_pkg;

  // ======================================================================
  // Widths
  // ======================================================================
  localparam int ADDR_W      = 12;
  localparam int DATA_W      = 32;
  localparam int KEY_DWORDS  = 8;
  localparam int KEY_W       = 256;
  localparam int ENTRY_W     = 5;
  localparam int OFFSET_W    = 3;
  localparam int SEED_CHUNKS = 9;
  localparam int SEED_W      = 288;
  localparam int SEED_IDX_W  = 4;

  // Data windows of four words each
  localparam logic [ADDR_W-1:0] DATA_IN_BASE  = 12'h050;
  localparam logic [ADDR_W-1:0] DATA_OUT_BASE = 12'h060;

  // ======================================================================
  // Register port
  // ======================================================================
  typedef struct packed {
    logic              dv;
    logic              write;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic              hold;
    logic              error;
    logic [DATA_W-1:0] rdata;
  } bus_rsp_t;

  // ======================================================================
  // Key vault read port
  // ======================================================================
  typedef struct packed {
    logic                valid;
    logic [ENTRY_W-1:0]  entry;
    logic [OFFSET_W-1:0] offset;
  } kv_rd_req_t;

  typedef struct packed {
    logic              valid;
    logic              error;
    logic [DATA_W-1:0] data;
  } kv_rd_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } key_load_state_e;

endpackage

// File: hw/dword_counter.sv
// Dword offset counter for a key load with last dword flag
`timescale 1ns/1ns

module dword_counter (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               clear_i,
  input  logic                               step_i,
  output logic [aes_front_pkg::OFFSET_W-1:0] offset_o,
  output logic                               last_o
);
  import aes_front_pkg::*;

  logic [OFFSET_W-1:0] offset_q;

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      offset_q <= '0;
    end else if (clear_i) begin
      offset_q <= '0;
    end else if (step_i) begin
      offset_q <= offset_q + 1'b1;
    end
  end

  assign offset_o = offset_q;
  assign last_o   = (offset_q == OFFSET_W'(KEY_DWORDS - 1));

endmodule

// File: hw/req_merge.sv
// Request merge of host and DMA ports onto the engine port with window byte swap
`timescale 1ns/1ns

module req_merge (
  input  aes_front_pkg::bus_req_t host_req_i,
  input  aes_front_pkg::bus_req_t dma_req_i,
  output aes_front_pkg::bus_rsp_t host_rsp_o,
  output aes_front_pkg::bus_rsp_t dma_rsp_o,
  output aes_front_pkg::bus_req_t eng_req_o,
  input  aes_front_pkg::bus_rsp_t eng_rsp_i,
  input  logic                    swap_en_i
);
  import aes_front_pkg::*;

  logic              collision;
  logic              in_window;
  logic              swap;
  logic [DATA_W-1:0] rdata_post;

  // Reverse the four bytes of a word
  function automatic logic [DATA_W-1:0] byte_swap(input logic [DATA_W-1:0] d);
    logic [DATA_W-1:0] r;
    for (int b = 0; b < DATA_W/8; b++) begin
      r[b*8 +: 8] = d[(DATA_W/8-1-b)*8 +: 8];
    end
    return r;
  endfunction

  // Ports are kept apart by firmware and a clash is only flagged
  assign collision = host_req_i.dv & dma_req_i.dv;

  // DMA takes priority for the payload
  assign eng_req_o.dv    = host_req_i.dv | dma_req_i.dv;
  assign eng_req_o.write = dma_req_i.dv ? dma_req_i.write : host_req_i.write;
  assign eng_req_o.addr  = dma_req_i.dv ? dma_req_i.addr  : host_req_i.addr;

  // Word aligned hit in either 16-byte data window
  assign in_window = (eng_req_o.addr[1:0] == 2'b00) &&
                     ((eng_req_o.addr[ADDR_W-1:4] == DATA_IN_BASE[ADDR_W-1:4]) ||
                      (eng_req_o.addr[ADDR_W-1:4] == DATA_OUT_BASE[ADDR_W-1:4]));
  assign swap = eng_req_o.dv & swap_en_i & in_window;

  assign eng_req_o.wdata = swap ? byte_swap(dma_req_i.dv ? dma_req_i.wdata : host_req_i.wdata)
                                : (dma_req_i.dv ? dma_req_i.wdata : host_req_i.wdata);
  assign rdata_post = swap ? byte_swap(eng_rsp_i.rdata) : eng_rsp_i.rdata;

  // Responses back to each requester
  assign host_rsp_o.hold  = host_req_i.dv & eng_rsp_i.hold;
  assign host_rsp_o.error = (host_req_i.dv & eng_rsp_i.error) | collision;
  assign host_rsp_o.rdata = host_req_i.dv ? rdata_post : '0;

  assign dma_rsp_o.hold  = dma_req_i.dv & eng_rsp_i.hold;
  assign dma_rsp_o.error = (dma_req_i.dv & eng_rsp_i.error) | collision;
  assign dma_rsp_o.rdata = dma_req_i.dv ? rdata_post : '0;

endmodule

// File: hw/key_load_fsm.sv
// Key load FSM issuing one key-vault read per dword and reporting done or error
`timescale 1ns/1ns

module key_load_fsm (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               read_en_i,
  input  logic [aes_front_pkg::ENTRY_W-1:0]  read_entry_i,
  input  logic                               engine_idle_i,
  input  logic                               engine_ready_i,
  input  logic                               clear_secrets_i,
  output aes_front_pkg::kv_rd_req_t          kv_rd_req_o,
  input  aes_front_pkg::kv_rd_rsp_t          kv_rd_rsp_i,
  output logic                               kv_ready_o,
  output logic                               start_o,
  output logic                               done_o,
  output logic                               error_o,
  output logic [aes_front_pkg::OFFSET_W-1:0] offset_o
);
  import aes_front_pkg::*;

  key_load_state_e    state_q;
  key_load_state_e    state_d;
  logic [ENTRY_W-1:0] entry_q;
  logic               rsp_good;
  logic               rsp_bad;
  logic               last;
  logic               done_q;
  logic               error_q;

  assign kv_ready_o = (state_q == IDLE);
  // Requests are taken only with the engine idle and ready
  assign start_o    = read_en_i & kv_ready_o & engine_idle_i & engine_ready_i;
  assign rsp_good   = (state_q == WAIT) & kv_rd_rsp_i.valid & ~kv_rd_rsp_i.error;
  assign rsp_bad    = (state_q == WAIT) & kv_rd_rsp_i.valid & kv_rd_rsp_i.error;

  dword_counter u_dword_counter (
    .clk      (clk),
    .reset_n  (reset_n),
    .clear_i  (start_o),
    .step_i   (rsp_good & ~last),
    .offset_o (offset_o),
    .last_o   (last)
  );

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: if (start_o) state_d = REQ;
      REQ:  state_d = WAIT;
      WAIT: begin
        if (rsp_bad || (rsp_good && last)) begin
          state_d = IDLE;
        end else if (rsp_good) begin
          state_d = REQ;
        end
      end
      default: state_d = IDLE;
    endcase
    if (clear_secrets_i) begin
      state_d = IDLE;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= IDLE;
      done_q  <= 1'b0;
      error_q <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= rsp_good & last & ~clear_secrets_i;
      error_q <= rsp_bad & ~clear_secrets_i;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      entry_q <= '0;
    end else if (start_o) begin
      entry_q <= read_entry_i;
    end
  end

  // One request cycle per dword
  assign kv_rd_req_o.valid  = (state_q == REQ);
  assign kv_rd_req_o.entry  = entry_q;
  assign kv_rd_req_o.offset = offset_o;

  assign done_o  = done_q;
  assign error_o = error_q;

endmodule

// File: hw/key_buffer.sv
// Key buffer staging swizzled vault dwords and presenting the key with valid
`timescale 1ns/1ns

module key_buffer (
  input  logic                               clk,
  input  logic                               reset_n,
  input  logic                               write_i,
  input  logic [aes_front_pkg::OFFSET_W-1:0] offset_i,
  input  logic [aes_front_pkg::DATA_W-1:0]   data_i,
  input  logic                               commit_i,
  input  logic                               invalidate_i,
  input  logic                               clear_secrets_i,
  output logic [aes_front_pkg::KEY_W-1:0]    key_o,
  output logic                               key_valid_o
);
  import aes_front_pkg::*;

  logic [KEY_DWORDS-1:0][DATA_W-1:0] stage_q;
  logic [DATA_W-1:0]                 data_swz;

  // Vault words arrive in the opposite byte order to the engine
  always_comb begin
    for (int b = 0; b < DATA_W/8; b++) begin
      data_swz[b*8 +: 8] = data_i[(DATA_W/8-1-b)*8 +: 8];
    end
  end

  // ======================================================================
  // Staging register
  // ======================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      stage_q <= '0;
    end else if (invalidate_i || clear_secrets_i) begin
      stage_q <= '0;
    end else if (write_i) begin
      for (int k = 0; k < KEY_DWORDS; k++) begin
        if (offset_i == OFFSET_W'(k)) begin
          stage_q[k] <= data_swz;
        end else if (offset_i == '0) begin
          // First dword wipes whatever an older key left behind
          stage_q[k] <= '0;
        end
      end
    end
  end

  // ======================================================================
  // Presented key
  // ======================================================================
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      key_o       <= '0;
      key_valid_o <= 1'b0;
    end else if (invalidate_i || clear_secrets_i) begin
      key_o       <= '0;
      key_valid_o <= 1'b0;
    end else if (commit_i) begin
      key_o       <= stage_q;
      key_valid_o <= 1'b1;
    end
  end

endmodule

// File: hw/seed_collector.sv
// Seed collector gathering nine chunks and pulsing reseed once all are written
`timescale 1ns/1ns

module seed_collector (
  input  logic                                 clk,
  input  logic                                 reset_n,
  input  logic                                 seed_we_i,
  input  logic [aes_front_pkg::SEED_IDX_W-1:0] seed_idx_i,
  input  logic [aes_front_pkg::DATA_W-1:0]     seed_data_i,
  output logic [aes_front_pkg::SEED_W-1:0]     seed_o,
  output logic                                 reseed_o
);
  import aes_front_pkg::*;

  logic [SEED_CHUNKS-1:0][DATA_W-1:0] chunk_q;
  logic [SEED_CHUNKS-1:0]             written_q;
  logic [SEED_CHUNKS-1:0]             we_mask;

  // Indexes past the last chunk are dropped
  always_comb begin
    we_mask = '0;
    for (int i = 0; i < SEED_CHUNKS; i++) begin
      we_mask[i] = seed_we_i && (seed_idx_i == SEED_IDX_W'(i));
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      chunk_q   <= '0;
      written_q <= '0;
    end else begin
      for (int i = 0; i < SEED_CHUNKS; i++) begin
        if (we_mask[i]) begin
          chunk_q[i] <= seed_data_i;
        end
      end
      // Tracking restarts on the reseed cycle
      written_q <= (reseed_o ? '0 : written_q) | we_mask;
    end
  end

  assign reseed_o = &written_q;
  assign seed_o   = chunk_q;

endmodule

// File: hw/aes_front_top.sv
// AES front end top level joining request merge, key load and seed collection
`timescale 1ns/1ns

module aes_front_top (
  input  logic                               clk,
  input  logic                               reset_n,
  // Register ports
  input  aes_front_pkg::bus_req_t            host_req_i,
  input  aes_front_pkg::bus_req_t            dma_req_i,
  output aes_front_pkg::bus_rsp_t            host_rsp_o,
  output aes_front_pkg::bus_rsp_t            dma_rsp_o,
  output aes_front_pkg::bus_req_t            eng_req_o,
  input  aes_front_pkg::bus_rsp_t            eng_rsp_i,
  input  logic                               swap_en_i,
  // Engine status
  input  logic                               engine_idle_i,
  input  logic                               engine_ready_i,
  // Key request and vault
  input  logic                               read_en_i,
  input  logic [aes_front_pkg::ENTRY_W-1:0]  read_entry_i,
  output aes_front_pkg::kv_rd_req_t          kv_rd_req_o,
  input  aes_front_pkg::kv_rd_rsp_t          kv_rd_rsp_i,
  output logic [aes_front_pkg::KEY_W-1:0]    key_o,
  output logic                               key_valid_o,
  output logic                               kv_ready_o,
  output logic                               key_error_o,
  input  logic                               clear_secrets_i,
  // Seed
  input  logic                               seed_we_i,
  input  logic [aes_front_pkg::SEED_IDX_W-1:0] seed_idx_i,
  input  logic [aes_front_pkg::DATA_W-1:0]   seed_data_i,
  output logic [aes_front_pkg::SEED_W-1:0]   seed_o,
  output logic                               reseed_o
);
  import aes_front_pkg::*;

  logic                load_start;
  logic                load_done;
  logic                load_error;
  logic [OFFSET_W-1:0] load_offset;
  logic                dword_write;
  logic                key_invalidate;

  // ======================================================================
  // Register port merge
  // ======================================================================
  req_merge u_req_merge (
    .host_req_i (host_req_i),
    .dma_req_i  (dma_req_i),
    .host_rsp_o (host_rsp_o),
    .dma_rsp_o  (dma_rsp_o),
    .eng_req_o  (eng_req_o),
    .eng_rsp_i  (eng_rsp_i),
    .swap_en_i  (swap_en_i)
  );

  // ======================================================================
  // Key load
  // ======================================================================
  key_load_fsm u_key_load_fsm (
    .clk             (clk),
    .reset_n         (reset_n),
    .read_en_i       (read_en_i),
    .read_entry_i    (read_entry_i),
    .engine_idle_i   (engine_idle_i),
    .engine_ready_i  (engine_ready_i),
    .clear_secrets_i (clear_secrets_i),
    .kv_rd_req_o     (kv_rd_req_o),
    .kv_rd_rsp_i     (kv_rd_rsp_i),
    .kv_ready_o      (kv_ready_o),
    .start_o         (load_start),
    .done_o          (load_done),
    .error_o         (load_error),
    .offset_o        (load_offset)
  );

  // Good vault dword while a load is running
  assign dword_write    = kv_rd_rsp_i.valid & ~kv_rd_rsp_i.error & ~kv_ready_o;
  assign key_invalidate = load_start | load_error;
  assign key_error_o    = load_error;

  key_buffer u_key_buffer (
    .clk             (clk),
    .reset_n         (reset_n),
    .write_i         (dword_write),
    .offset_i        (load_offset),
    .data_i          (kv_rd_rsp_i.data),
    .commit_i        (load_done),
    .invalidate_i    (key_invalidate),
    .clear_secrets_i (clear_secrets_i),
    .key_o           (key_o),
    .key_valid_o     (key_valid_o)
  );

  // ======================================================================
  // Seed collection
  // ======================================================================
  seed_collector u_seed_collector (
    .clk         (clk),
    .reset_n     (reset_n),
    .seed_we_i   (seed_we_i),
    .seed_idx_i  (seed_idx_i),
    .seed_data_i (seed_data_i),
    .seed_o      (seed_o),
    .reseed_o    (reseed_o)
  );

endmodule

// File: test/aes_front_props.sv
// Concurrent properties on key stability, vault request timing and reseed pulses
`timescale 1ns/1ns

module aes_front_props (
  input logic                            clk,
  input logic                            reset_n,
  input logic [aes_front_pkg::KEY_W-1:0] key_o,
  input logic                            key_valid_o,
  input logic                            read_en_i,
  input logic                            engine_idle_i,
  input logic                            engine_ready_i,
  input logic                            clear_secrets_i,
  input logic                            kv_ready_o,
  input aes_front_pkg::kv_rd_req_t       kv_rd_req_o,
  input logic                            reseed_o
);
  import aes_front_pkg::*;

  logic accept;

  assign accept = read_en_i & kv_ready_o & engine_idle_i & engine_ready_i;

  // Presented key only changes on a new load or a clear
  key_stable_a: assert property (@(posedge clk) disable iff (!reset_n)
    (key_valid_o && !accept && !clear_secrets_i) |=> $stable(key_o))
    else $error("key_o changed while valid");

  req_not_idle_a: assert property (@(posedge clk) disable iff (!reset_n)
    !(kv_rd_req_o.valid && kv_ready_o))
    else $error("vault request issued in IDLE");

  reseed_single_a: assert property (@(posedge clk) disable iff (!reset_n)
    reseed_o |=> !reseed_o)
    else $error("reseed_o high two cycles in a row");

endmodule

bind aes_front_top aes_front_props u_props (
  .clk             (clk),
  .reset_n         (reset_n),
  .key_o           (key_o),
  .key_valid_o     (key_valid_o),
  .read_en_i       (read_en_i),
  .engine_idle_i   (engine_idle_i),
  .engine_ready_i  (engine_ready_i),
  .clear_secrets_i (clear_secrets_i),
  .kv_ready_o      (kv_ready_o),
  .kv_rd_req_o     (kv_rd_req_o),
  .reseed_o        (reseed_o)
);

// File: test/tb_aes_front.sv
// Testbench for the AES front end with random stimulus, a key-vault model and checks
`timescale 1ns/1ns

module tb_aes_front;
  import aes_front_pkg::*;

  localparam int N_MERGE    = 400;
  localparam int N_SEED     = 400;
  localparam int N_LOADS    = 12;
  // Worst case per load is eight dwords at one request and three wait cycles each
  localparam int LOAD_CYCLES = KEY_DWORDS * 5 + 30;
  localparam int CYCLE_LIMIT = 10 + N_MERGE + N_SEED + (N_LOADS + 6) * LOAD_CYCLES + 200;
  localparam logic [15:0] LFSR_SEED = 16'd315;
  localparam logic [2:0][ENTRY_W-1:0] LOCKED = {5'd30, 5'd17, 5'd3};

  logic                clk;
  logic                reset_n;
  bus_req_t            host_req;
  bus_req_t            dma_req;
  bus_rsp_t            host_rsp;
  bus_rsp_t            dma_rsp;
  bus_req_t            eng_req;
  bus_rsp_t            eng_rsp;
  logic                swap_en;
  logic                engine_idle;
  logic                engine_ready;
  logic                read_en;
  logic [ENTRY_W-1:0]  read_entry;
  kv_rd_req_t          kv_req;
  kv_rd_rsp_t          kv_rsp = '0;
  logic [KEY_W-1:0]    key;
  logic                key_valid;
  logic                kv_ready;
  logic                key_error;
  logic                clear_secrets;
  logic                seed_we;
  logic [SEED_IDX_W-1:0] seed_idx;
  logic [DATA_W-1:0]   seed_data;
  logic [SEED_W-1:0]   seed;
  logic                reseed;

  logic [15:0]         lfsr_q;
  logic [15:0]         vault_lfsr = LFSR_SEED;
  logic [DATA_W-1:0]   vault [32][KEY_DWORDS];
  logic                vault_pend = 1'b0;
  int                  vault_wait;
  logic [1:0]          vault_lat;
  logic [ENTRY_W-1:0]  pend_entry;
  logic [OFFSET_W-1:0] pend_off;
  logic [ENTRY_W-1:0]  exp_entry = '0;
  int                  req_count = 0;
  int                  req_base = 0;
  int                  cycles = 0;
  int                  bus_errs = 0;
  int                  key_errs = 0;
  int                  vault_errs = 0;
  int                  seed_errs = 0;
  int                  flag_errs = 0;
  int                  other_errs = 0;

  aes_front_top uut (
    .clk             (clk),
    .reset_n         (reset_n),
    .host_req_i      (host_req),
    .dma_req_i       (dma_req),
    .host_rsp_o      (host_rsp),
    .dma_rsp_o       (dma_rsp),
    .eng_req_o       (eng_req),
    .eng_rsp_i       (eng_rsp),
    .swap_en_i       (swap_en),
    .engine_idle_i   (engine_idle),
    .engine_ready_i  (engine_ready),
    .read_en_i       (read_en),
    .read_entry_i    (read_entry),
    .kv_rd_req_o     (kv_req),
    .kv_rd_rsp_i     (kv_rsp),
    .key_o           (key),
    .key_valid_o     (key_valid),
    .kv_ready_o      (kv_ready),
    .key_error_o     (key_error),
    .clear_secrets_i (clear_secrets),
    .seed_we_i       (seed_we),
    .seed_idx_i      (seed_idx),
    .seed_data_i     (seed_data),
    .seed_o          (seed),
    .reseed_o        (reseed)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ======================================================================
  // Random numbers and reference functions
  // ======================================================================
  function automatic logic [15:0] galois_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  function automatic logic rand_bit();
    lfsr_q = galois_step(lfsr_q);
    return lfsr_q[0];
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], rand_bit()};
    end
    return r;
  endfunction

  function automatic logic [DATA_W-1:0] reverse_bytes(input logic [DATA_W-1:0] d);
    return {d[7:0], d[15:8], d[23:16], d[31:24]};
  endfunction

  function automatic logic in_data_window(input logic [ADDR_W-1:0] a);
    logic hit;
    hit = 1'b0;
    for (int w = 0; w < 4; w++) begin
      if (a == DATA_IN_BASE + ADDR_W'(4 * w) || a == DATA_OUT_BASE + ADDR_W'(4 * w)) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  function automatic logic is_locked(input logic [ENTRY_W-1:0] e);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < $size(LOCKED); i++) begin
      if (LOCKED[i] == e) hit = 1'b1;
    end
    return hit;
  endfunction

  function automatic logic [KEY_W-1:0] expected_key(input logic [ENTRY_W-1:0] e);
    logic [KEY_W-1:0] r;
    for (int k = 0; k < KEY_DWORDS; k++) begin
      r[k*DATA_W +: DATA_W] = reverse_bytes(vault[e][k]);
    end
    return r;
  endfunction

  // Mix of window hits, misaligned window bytes and random addresses
  function automatic bus_req_t random_req();
    bus_req_t   r;
    logic [1:0] sel;
    logic [1:0] word;
    r.dv    = rand_bit();
    r.write = rand_bit();
    sel     = 2'(rand_bits(2));
    word    = 2'(rand_bits(2));
    case (sel)
      2'd0:    r.addr = ADDR_W'(rand_bits(ADDR_W));
      2'd1:    r.addr = DATA_IN_BASE + ADDR_W'({word, 2'b00});
      2'd2:    r.addr = DATA_OUT_BASE + ADDR_W'({word, 2'b00});
      default: r.addr = DATA_IN_BASE + ADDR_W'(rand_bits(4));
    endcase
    r.wdata = rand_bits(DATA_W);
    return r;
  endfunction

  // ======================================================================
  // Compare tasks
  // ======================================================================
  task automatic check_rsp(input string name, input bus_rsp_t exp, input bus_rsp_t act);
    if (act !== exp) begin
      bus_errs++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_req(input string name, input bus_req_t exp, input bus_req_t act);
    if (act !== exp) begin
      bus_errs++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_key(input string name, input logic [KEY_W-1:0] exp,
                           input logic [KEY_W-1:0] act);
    if (act !== exp) begin
      key_errs++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_kv_req(input string name, input kv_rd_req_t exp, input kv_rd_req_t act);
    if (act !== exp) begin
      vault_errs++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_seed(input string name, input logic [SEED_W-1:0] exp,
                            input logic [SEED_W-1:0] act);
    if (act !== exp) begin
      seed_errs++;
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      flag_errs++;
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  // ======================================================================
  // Key-vault model
  // ======================================================================
  always @(posedge clk) begin
    kv_rsp <= '0;
    if (kv_req.valid) begin
      check_kv_req("kv_rd_req_o", {1'b1, exp_entry, OFFSET_W'(req_count - req_base)}, kv_req);
      req_count++;
      pend_entry = kv_req.entry;
      pend_off   = kv_req.offset;
      vault_lfsr = galois_step(vault_lfsr);
      vault_lat[0] = vault_lfsr[0];
      vault_lfsr = galois_step(vault_lfsr);
      vault_lat[1] = vault_lfsr[0];
      vault_wait = (vault_lat == 2'd3) ? 2 : int'(vault_lat);
      vault_pend = 1'b1;
    end else if (vault_pend && vault_wait > 0) begin
      vault_wait--;
    end
    if (vault_pend && vault_wait == 0) begin
      kv_rsp     <= {1'b1, is_locked(pend_entry), vault[pend_entry][pend_off]};
      vault_pend = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: test did not finish");
      $display("Some tests failed");
      $finish;
    end
  end

  // ======================================================================
  // Test phases
  // ======================================================================
  task automatic run_merge();
    bus_req_t h;
    bus_req_t d;
    bus_rsp_t e;
    bus_req_t exp_eng;
    bus_rsp_t exp_h;
    bus_rsp_t exp_d;
    logic     sw_en;
    logic     sw;
    logic [DATA_W-1:0] rd;
    for (int i = 0; i < N_MERGE; i++) begin
      @(posedge clk);
      h       = random_req();
      d       = random_req();
      e.hold  = rand_bit();
      e.error = rand_bit();
      e.rdata = rand_bits(DATA_W);
      sw_en   = rand_bit();
      host_req <= h;
      dma_req  <= d;
      eng_rsp  <= e;
      swap_en  <= sw_en;
      @(negedge clk);
      exp_eng.dv    = h.dv | d.dv;
      exp_eng.write = d.dv ? d.write : h.write;
      exp_eng.addr  = d.dv ? d.addr : h.addr;
      sw            = exp_eng.dv && sw_en && in_data_window(exp_eng.addr);
      exp_eng.wdata = d.dv ? d.wdata : h.wdata;
      if (sw) exp_eng.wdata = reverse_bytes(exp_eng.wdata);
      rd = sw ? reverse_bytes(e.rdata) : e.rdata;
      exp_h.hold  = h.dv & e.hold;
      exp_h.error = (h.dv & e.error) | (h.dv & d.dv);
      exp_h.rdata = h.dv ? rd : '0;
      exp_d.hold  = d.dv & e.hold;
      exp_d.error = (d.dv & e.error) | (h.dv & d.dv);
      exp_d.rdata = d.dv ? rd : '0;
      check_req("eng_req_o", exp_eng, eng_req);
      check_rsp("host_rsp_o", exp_h, host_rsp);
      check_rsp("dma_rsp_o", exp_d, dma_rsp);
    end
    @(posedge clk);
    host_req <= '0;
    dma_req  <= '0;
  endtask

  task automatic run_seed();
    logic [DATA_W-1:0]      chunks [SEED_CHUNKS];
    logic [SEED_CHUNKS-1:0] written;
    logic [SEED_W-1:0]      exp_seed;
    int                     reseeds;
    written = '0;
    reseeds = 0;
    for (int k = 0; k < SEED_CHUNKS; k++) chunks[k] = '0;
    for (int i = 0; i < N_SEED; i++) begin
      @(posedge clk);
      // Model takes the write the DUT samples on this edge
      if (&written) written = '0;
      if (seed_we && seed_idx < SEED_CHUNKS) begin
        chunks[seed_idx]  = seed_data;
        written[seed_idx] = 1'b1;
      end
      seed_we   <= rand_bit();
      seed_idx  <= SEED_IDX_W'(rand_bits(SEED_IDX_W));
      seed_data <= rand_bits(DATA_W);
      @(negedge clk);
      for (int k = 0; k < SEED_CHUNKS; k++) exp_seed[k*DATA_W +: DATA_W] = chunks[k];
      check_bit("reseed_o", &written, reseed);
      check_seed("seed_o", exp_seed, seed);
      if (reseed) reseeds++;
    end
    @(posedge clk);
    seed_we <= 1'b0;
    if (reseeds == 0) begin
      other_errs++;
      $display("No reseed pulse was seen during the seed phase");
    end
  endtask

  task automatic start_load(input logic [ENTRY_W-1:0] e);
    @(posedge clk);
    read_en    <= 1'b1;
    read_entry <= e;
    exp_entry  = e;
    req_base   = req_count;
    @(posedge clk);
    read_en <= 1'b0;
  endtask

  // A second request in flight must be dropped
  task automatic load_and_check(input logic [ENTRY_W-1:0] e, input logic poke);
    start_load(e);
    @(negedge clk);
    check_bit("key_valid_o", 1'b0, key_valid);
    check_key("key_o", '0, key);
    if (poke) begin
      @(posedge clk);
      read_en    <= 1'b1;
      read_entry <= e ^ 5'h1F;
      @(posedge clk);
      read_en <= 1'b0;
      @(negedge clk);
    end
    while (!(key_valid || key_error)) @(negedge clk);
    if (is_locked(e)) begin
      check_bit("key_error_o", 1'b1, key_error);
      check_bit("key_valid_o", 1'b0, key_valid);
      if (req_count - req_base != 1) begin
        other_errs++;
        $display("Locked entry %0d took %0d vault reads", e, req_count - req_base);
      end
      @(negedge clk);
      check_bit("key_error_o", 1'b0, key_error);
      check_bit("key_valid_o", 1'b0, key_valid);
      check_key("key_o", '0, key);
    end else begin
      check_bit("key_error_o", 1'b0, key_error);
      check_key("key_o", expected_key(e), key);
      if (req_count - req_base != KEY_DWORDS) begin
        other_errs++;
        $display("Entry %0d took %0d vault reads", e, req_count - req_base);
      end
    end
  endtask

  task automatic ignored_request(input logic idle, input logic ready, input logic [ENTRY_W-1:0] e);
    int count0;
    count0 = req_count;
    @(posedge clk);
    engine_idle  <= idle;
    engine_ready <= ready;
    read_en      <= 1'b1;
    read_entry   <= 5'd4;
    @(posedge clk);
    read_en      <= 1'b0;
    engine_idle  <= 1'b1;
    engine_ready <= 1'b1;
    repeat (6) @(negedge clk);
    if (req_count != count0) begin
      other_errs++;
      $display("A request with the engine busy reached the vault");
    end
    check_bit("key_valid_o", 1'b1, key_valid);
    check_key("key_o", expected_key(e), key);
  endtask

  task automatic pulse_clear();
    @(posedge clk);
    clear_secrets <= 1'b1;
    @(posedge clk);
    clear_secrets <= 1'b0;
    @(negedge clk);
    check_bit("key_valid_o", 1'b0, key_valid);
    check_bit("kv_ready_o", 1'b1, kv_ready);
    check_key("key_o", '0, key);
  endtask

  task automatic run_keys();
    logic [ENTRY_W-1:0] e;
    load_and_check(LOCKED[1], 1'b0);
    for (int i = 0; i < N_LOADS; i++) begin
      e = ENTRY_W'(rand_bits(ENTRY_W));
      load_and_check(e, 1'b0);
    end
    load_and_check(5'd9, 1'b0);
    ignored_request(1'b0, 1'b1, 5'd9);
    ignored_request(1'b1, 1'b0, 5'd9);
    load_and_check(5'd12, 1'b1);
    // Clear in the middle of a load and wait longer than the whole load could take
    start_load(5'd6);
    repeat (5) @(negedge clk);
    pulse_clear();
    repeat (KEY_DWORDS * 5) @(negedge clk);
    check_bit("key_error_o", 1'b0, key_error);
    check_bit("key_valid_o", 1'b0, key_valid);
    check_key("key_o", '0, key);
    load_and_check(5'd7, 1'b0);
    pulse_clear();
  endtask

  // ======================================================================
  // Main sequence
  // ======================================================================
  initial begin
    reset_n       = 1'b0;
    host_req      = '0;
    dma_req       = '0;
    eng_rsp       = '0;
    swap_en       = 1'b0;
    engine_idle   = 1'b1;
    engine_ready  = 1'b1;
    read_en       = 1'b0;
    read_entry    = '0;
    clear_secrets = 1'b0;
    seed_we       = 1'b0;
    seed_idx      = '0;
    seed_data     = '0;
    lfsr_q        = LFSR_SEED;
    for (int v = 0; v < 32; v++) begin
      for (int k = 0; k < KEY_DWORDS; k++) vault[v][k] = rand_bits(DATA_W);
    end
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);
    check_bit("kv_ready_o", 1'b1, kv_ready);
    check_bit("kv_rd_req_o.valid", 1'b0, kv_req.valid);
    check_bit("key_valid_o", 1'b0, key_valid);
    check_bit("key_error_o", 1'b0, key_error);
    check_bit("reseed_o", 1'b0, reseed);
    check_key("key_o", '0, key);
    check_seed("seed_o", '0, seed);
    run_merge();
    run_seed();
    run_keys();
    $display("errors: bus %0d, key %0d, vault %0d, seed %0d, flag %0d, other %0d",
             bus_errs, key_errs, vault_errs, seed_errs, flag_errs, other_errs);
    if (bus_errs + key_errs + vault_errs + seed_errs + flag_errs + other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/aes_front_pkg.sv
hw/dword_counter.sv
hw/req_merge.sv
hw/key_load_fsm.sv
hw/key_buffer.sv
hw/seed_collector.sv
hw/aes_front_top.sv
test/aes_front_props.sv
test/tb_aes_front.sv
